/* include/lane_params.svh */
// Lane edge front end sizes, region bounds, FIFO depth and edge threshold
`ifndef LANE_PARAMS_SVH
`define LANE_PARAMS_SVH

// Frame size in pixels
`define IMG_WIDTH 16
`define IMG_HEIGHT 8

// Reduced rectangle around the lane mask, bounds inclusive
`define ROI_START_X 2
`define ROI_END_X 13
`define ROI_START_Y 1
`define ROI_END_Y 6

// Entries in each input FIFO
`define FIFO_DEPTH 8

// Grayscale step that must be exceeded to mark an edge
`define EDGE_THRESHOLD 20

// Width of the per-frame masked edge count
`define COUNT_BITS 8

`endif

/* source/lane_pkg.sv */
// Pixel, position and path result types for the lane edge front end
`include "lane_params.svh"

package lane_pkg;

    localparam int COL_BITS = $clog2(`IMG_WIDTH);
    localparam int ROW_BITS = $clog2(`IMG_HEIGHT);

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    typedef struct packed {
        logic [COL_BITS-1:0] col;
        logic [ROW_BITS-1:0] row;
    } pixel_pos_t;

    typedef struct packed {
        pixel_pos_t pos;
        logic       is_edge;
    } edge_result_t;

    typedef struct packed {
        pixel_pos_t pos;
        logic       in_region;
    } region_result_t;

    typedef struct packed {
        pixel_pos_t pos;
        logic       masked_edge;
    } lane_pixel_t;

    // Mean of the three channels, truncated
    function automatic logic [7:0] rgb_to_gray(rgb_t px);
        logic [9:0] sum;
        sum = 10'(px.red) + 10'(px.green) + 10'(px.blue);
        return 8'(sum / 10'd3);
    endfunction

endpackage

/* source/pixel_fifo.sv */
// Show-ahead synchronous FIFO holding one RGB input stream
`timescale 1ns/1ps
`include "lane_params.svh"

module pixel_fifo #(
    parameter int DEPTH = `FIFO_DEPTH
) (
    input  logic          clock,
    input  logic          reset,
    input  logic          wr_en,
    input  lane_pkg::rgb_t din,
    input  logic          rd_en,
    output lane_pkg::rgb_t dout,
    output logic          full,
    output logic          empty
);
    import lane_pkg::*;

    localparam int PTR_BITS = $clog2(DEPTH);
    localparam int CNT_BITS = $clog2(DEPTH + 1);
    localparam logic [PTR_BITS-1:0] LAST_SLOT = PTR_BITS'(DEPTH - 1);

    rgb_t                mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                wr_ok;
    logic                rd_ok;

    assign full  = (count == CNT_BITS'(DEPTH));
    assign empty = (count == '0);
    assign wr_ok = wr_en && !full;
    assign rd_ok = rd_en && !empty;

    // Head of the queue is always on the output
    assign dout = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (wr_ok) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + PTR_BITS'(1);
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + PTR_BITS'(1);
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + CNT_BITS'(1);
                2'b01:   count <= count - CNT_BITS'(1);
                default: count <= count;
            endcase
        end
    end

    // Driver must respect full, and the consumer must respect empty
    a_no_write_when_full: assert property (
        @(posedge clock) disable iff (reset) !(wr_en && full)
    ) else $error("pixel_fifo write while full, pixel dropped");

    a_no_read_when_empty: assert property (
        @(posedge clock) disable iff (reset) !(rd_en && empty)
    ) else $error("pixel_fifo read while empty");

endmodule

/* source/edge_detector.sv */
// Image path: grayscale conversion and horizontal intensity edge flag
`timescale 1ns/1ps
`include "lane_params.svh"

module edge_detector (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  pair_valid,
    input  lane_pkg::pixel_pos_t  pair_pos,
    input  lane_pkg::rgb_t        pixel,
    output logic                  edge_valid,
    output lane_pkg::edge_result_t edge_res
);
    import lane_pkg::*;

    localparam logic [7:0] THRESHOLD = 8'(`EDGE_THRESHOLD);

    logic [7:0] gray;
    logic [7:0] prev_gray;
    logic [7:0] diff;
    logic       row_start;
    logic       is_edge;

    assign gray = rgb_to_gray(pixel);

    // Absolute step against the pixel to the left
    assign diff = (gray > prev_gray) ? (gray - prev_gray) : (prev_gray - gray);

    // First column has no left neighbour in this row
    assign row_start = (pair_pos.col == '0);
    assign is_edge   = !row_start && (diff > THRESHOLD);

    always_ff @(posedge clock) begin
        if (reset) begin
            edge_valid <= 1'b0;
        end else begin
            edge_valid <= pair_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (pair_valid) begin
            prev_gray        <= gray;
            edge_res.pos     <= pair_pos;
            edge_res.is_edge <= is_edge;
        end
    end

endmodule

/* source/mask_region.sv */
// Mask path: grayscale conversion and lane region test inside the ROI rectangle
`timescale 1ns/1ps
`include "lane_params.svh"

module mask_region (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    pair_valid,
    input  lane_pkg::pixel_pos_t    pair_pos,
    input  lane_pkg::rgb_t          mask_pixel,
    output logic                    region_valid,
    output lane_pkg::region_result_t region_res
);
    import lane_pkg::*;

    localparam logic [COL_BITS-1:0] X_FIRST = COL_BITS'(`ROI_START_X);
    localparam logic [COL_BITS-1:0] X_LAST  = COL_BITS'(`ROI_END_X);
    localparam logic [ROW_BITS-1:0] Y_FIRST = ROW_BITS'(`ROI_START_Y);
    localparam logic [ROW_BITS-1:0] Y_LAST  = ROW_BITS'(`ROI_END_Y);

    logic [7:0] mask_gray;
    logic       in_rect;
    logic       in_region;

    assign mask_gray = rgb_to_gray(mask_pixel);

    assign in_rect = (pair_pos.col >= X_FIRST) && (pair_pos.col <= X_LAST) &&
                     (pair_pos.row >= Y_FIRST) && (pair_pos.row <= Y_LAST);

    // Pixel counts only where the mask is lit and inside the rectangle
    assign in_region = in_rect && (mask_gray != 8'd0);

    always_ff @(posedge clock) begin
        if (reset) begin
            region_valid <= 1'b0;
        end else begin
            region_valid <= pair_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (pair_valid) begin
            region_res.pos       <= pair_pos;
            region_res.in_region <= in_region;
        end
    end

endmodule

/* source/roi_combiner.sv */
// Pairs the two input streams, tracks frame position and counts masked edges
`timescale 1ns/1ps
`include "lane_params.svh"

module roi_combiner (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     image_empty,
    input  logic                     mask_empty,
    input  lane_pkg::rgb_t           image_head,
    input  lane_pkg::rgb_t           mask_head,
    input  logic                     edge_valid,
    input  lane_pkg::edge_result_t   edge_res,
    input  logic                     region_valid,
    input  lane_pkg::region_result_t region_res,
    output logic                     pair_pop,
    output logic                     pair_valid,
    output lane_pkg::pixel_pos_t     pair_pos,
    output lane_pkg::rgb_t           image_pixel,
    output lane_pkg::rgb_t           mask_pixel,
    output logic                     pixel_valid,
    output lane_pkg::lane_pixel_t    lane_pixel,
    output logic                     frame_done,
    output logic [`COUNT_BITS-1:0]   edge_count
);
    import lane_pkg::*;

    localparam int COUNT_W = `COUNT_BITS;
    localparam logic [COL_BITS-1:0] LAST_COL = COL_BITS'(`IMG_WIDTH - 1);
    localparam logic [ROW_BITS-1:0] LAST_ROW = ROW_BITS'(`IMG_HEIGHT - 1);

    pixel_pos_t         pos_q;
    logic [COUNT_W-1:0] count_acc;
    logic               hit;
    logic               last_pixel;

    // Both heads are consumed together, one pair per cycle
    assign pair_pop = !image_empty && !mask_empty;

    assign hit        = edge_res.is_edge && region_res.in_region;
    assign last_pixel = (edge_res.pos.col == LAST_COL) && (edge_res.pos.row == LAST_ROW);

    // Raster position of the next pair to be popped
    always_ff @(posedge clock) begin
        if (reset) begin
            pos_q      <= '0;
            pair_valid <= 1'b0;
        end else begin
            pair_valid <= pair_pop;
            if (pair_pop) begin
                if (pos_q.col == LAST_COL) begin
                    pos_q.col <= '0;
                    pos_q.row <= (pos_q.row == LAST_ROW) ? '0 : pos_q.row + ROW_BITS'(1);
                end else begin
                    pos_q.col <= pos_q.col + COL_BITS'(1);
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (pair_pop) begin
            pair_pos    <= pos_q;
            image_pixel <= image_head;
            mask_pixel  <= mask_head;
        end
    end

    // Output stage and per-frame count
    always_ff @(posedge clock) begin
        if (reset) begin
            pixel_valid <= 1'b0;
            frame_done  <= 1'b0;
            count_acc   <= '0;
            edge_count  <= '0;
        end else begin
            pixel_valid <= edge_valid;
            frame_done  <= edge_valid && last_pixel;
            if (edge_valid) begin
                if (last_pixel) begin
                    edge_count <= count_acc + COUNT_W'(hit);
                    count_acc  <= '0;
                end else begin
                    count_acc  <= count_acc + COUNT_W'(hit);
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (edge_valid) begin
            lane_pixel.pos         <= edge_res.pos;
            lane_pixel.masked_edge <= hit;
        end
    end

    // The two paths run in lockstep on the same pair
    a_paths_in_step: assert property (
        @(posedge clock) disable iff (reset) edge_valid == region_valid
    ) else $error("edge and region results out of step");

    a_paths_same_pos: assert property (
        @(posedge clock) disable iff (reset) edge_valid |-> (edge_res.pos == region_res.pos)
    ) else $error("edge and region results carry different positions");

    // Every popped pair leaves the pipeline three cycles later
    a_pop_to_output: assert property (
        @(posedge clock) disable iff (reset) pair_pop |-> ##3 pixel_valid
    ) else $error("popped pair did not reach the output in three cycles");

endmodule

/* source/lane_edge_top.sv */
// Lane edge front end: input FIFOs, image and mask paths, and the combiner
`timescale 1ns/1ps
`include "lane_params.svh"

module lane_edge_top (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   image_wr_en,
    input  lane_pkg::rgb_t         image_din,
    input  logic                   mask_wr_en,
    input  lane_pkg::rgb_t         mask_din,
    output logic                   image_full,
    output logic                   mask_full,
    output logic                   pixel_valid,
    output lane_pkg::lane_pixel_t  lane_pixel,
    output logic                   frame_done,
    output logic [`COUNT_BITS-1:0] edge_count
);
    import lane_pkg::*;

    // FIFO heads and status
    rgb_t           image_head;
    rgb_t           mask_head;
    logic           image_empty;
    logic           mask_empty;
    logic           pair_pop;

    // Registered pair towards both paths
    logic           pair_valid;
    pixel_pos_t     pair_pos;
    rgb_t           image_pixel;
    rgb_t           mask_pixel;

    // Path results
    logic           edge_valid;
    edge_result_t   edge_res;
    logic           region_valid;
    region_result_t region_res;

    pixel_fifo #(
        .DEPTH(`FIFO_DEPTH)
    ) u_image_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (image_wr_en),
        .din   (image_din),
        .rd_en (pair_pop),
        .dout  (image_head),
        .full  (image_full),
        .empty (image_empty)
    );

    pixel_fifo #(
        .DEPTH(`FIFO_DEPTH)
    ) u_mask_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (mask_wr_en),
        .din   (mask_din),
        .rd_en (pair_pop),
        .dout  (mask_head),
        .full  (mask_full),
        .empty (mask_empty)
    );

    edge_detector u_edge_detector (
        .clock      (clock),
        .reset      (reset),
        .pair_valid (pair_valid),
        .pair_pos   (pair_pos),
        .pixel      (image_pixel),
        .edge_valid (edge_valid),
        .edge_res   (edge_res)
    );

    mask_region u_mask_region (
        .clock        (clock),
        .reset        (reset),
        .pair_valid   (pair_valid),
        .pair_pos     (pair_pos),
        .mask_pixel   (mask_pixel),
        .region_valid (region_valid),
        .region_res   (region_res)
    );

    roi_combiner u_roi_combiner (
        .clock        (clock),
        .reset        (reset),
        .image_empty  (image_empty),
        .mask_empty   (mask_empty),
        .image_head   (image_head),
        .mask_head    (mask_head),
        .edge_valid   (edge_valid),
        .edge_res     (edge_res),
        .region_valid (region_valid),
        .region_res   (region_res),
        .pair_pop     (pair_pop),
        .pair_valid   (pair_valid),
        .pair_pos     (pair_pos),
        .image_pixel  (image_pixel),
        .mask_pixel   (mask_pixel),
        .pixel_valid  (pixel_valid),
        .lane_pixel   (lane_pixel),
        .frame_done   (frame_done),
        .edge_count   (edge_count)
    );

endmodule

/* dv/lane_edge_tb.sv */
// Lane edge front end testbench with frame stimulus, reference model, comparator and watchdog
`timescale 1ns/1ps
`include "lane_params.svh"

module lane_edge_tb;
    import lane_pkg::*;

    localparam int PIXELS          = `IMG_WIDTH * `IMG_HEIGHT;
    localparam int NUM_FRAMES      = 7;
    localparam int WATCHDOG_CYCLES = NUM_FRAMES * PIXELS * 4 + 500;
    localparam rgb_t BRIGHT        = '{red: 8'd200, green: 8'd90, blue: 8'd40};
    localparam rgb_t DARK          = '{red: 8'd0, green: 8'd0, blue: 8'd0};
    localparam rgb_t LIT_MASK      = '{red: 8'hff, green: 8'hff, blue: 8'hff};

    logic                   clock;
    logic                   reset;
    logic                   image_wr_en;
    rgb_t                   image_din;
    logic                   mask_wr_en;
    rgb_t                   mask_din;
    logic                   image_full;
    logic                   mask_full;
    logic                   pixel_valid;
    lane_pixel_t            lane_pixel;
    logic                   frame_done;
    logic [`COUNT_BITS-1:0] edge_count;

    // Frame being sent, and expected results in output order
    rgb_t        image_frame [PIXELS];
    rgb_t        mask_frame [PIXELS];
    bit          exp_flags [$];
    int          exp_counts [$];
    int          drive_errors;
    int          compare_errors;
    int          recv_pixels;
    int          recv_frames;
    int          sent_pairs;

    lane_edge_top u_lane_edge_top (
        .clock       (clock),
        .reset       (reset),
        .image_wr_en (image_wr_en),
        .image_din   (image_din),
        .mask_wr_en  (mask_wr_en),
        .mask_din    (mask_din),
        .image_full  (image_full),
        .mask_full   (mask_full),
        .pixel_valid (pixel_valid),
        .lane_pixel  (lane_pixel),
        .frame_done  (frame_done),
        .edge_count  (edge_count)
    );

    always #20 clock = ~clock;

    function automatic int gray_level(rgb_t px);
        return (int'(px.red) + int'(px.green) + int'(px.blue)) / 3;
    endfunction

    // Expected flag from the step against the left pixel, the ROI and the mask
    function automatic bit ref_masked_edge(int col, int row);
        int idx;
        int step;
        bit is_edge;
        bit in_roi;
        idx = row * `IMG_WIDTH + col;
        is_edge = 1'b0;
        if (col != 0) begin
            step = gray_level(image_frame[idx]) - gray_level(image_frame[idx - 1]);
            if (step < 0) begin
                step = -step;
            end
            is_edge = (step > `EDGE_THRESHOLD);
        end
        in_roi = (col >= `ROI_START_X) && (col <= `ROI_END_X) &&
                 (row >= `ROI_START_Y) && (row <= `ROI_END_Y);
        return is_edge && in_roi && (gray_level(mask_frame[idx]) != 0);
    endfunction

    task automatic queue_expected_frame();
        int count;
        bit flag;
        count = 0;
        for (int idx = 0; idx < PIXELS; idx++) begin
            flag = ref_masked_edge(idx % `IMG_WIDTH, idx / `IMG_WIDTH);
            exp_flags.push_back(flag);
            count += int'(flag);
        end
        exp_counts.push_back(count);
    endtask

    // Kind 0 random mask, 1 zero mask, 2 edges outside the ROI, 3 column stripes
    task automatic fill_frame(int kind);
        int col;
        int row;
        for (int idx = 0; idx < PIXELS; idx++) begin
            col = idx % `IMG_WIDTH;
            row = idx / `IMG_WIDTH;
            image_frame[idx] = 24'($urandom);
            mask_frame[idx]  = LIT_MASK;
            case (kind)
                0: mask_frame[idx] = ($urandom % 3 == 0) ? DARK : 24'($urandom);
                1: mask_frame[idx] = DARK;
                2: begin
                    if (row >= `ROI_START_Y && row <= `ROI_END_Y) begin
                        image_frame[idx] = (col == 0 || col == `IMG_WIDTH - 1) ? BRIGHT : DARK;
                    end
                end
                default: image_frame[idx] = ((col / 2) % 2 == 1) ? BRIGHT : DARK;
            endcase
        end
    endtask

    // Called on a falling edge, returns on the next one
    task automatic write_pair(int idx);
        while (image_full || mask_full) @(negedge clock);
        image_wr_en = 1'b1;
        image_din   = image_frame[idx];
        mask_wr_en  = 1'b1;
        mask_din    = mask_frame[idx];
        @(negedge clock);
        image_wr_en = 1'b0;
        mask_wr_en  = 1'b0;
        sent_pairs++;
    endtask

    task automatic send_frame(int max_gap);
        queue_expected_frame();
        for (int idx = 0; idx < PIXELS; idx++) begin
            repeat (int'($urandom % (max_gap + 1))) @(negedge clock);
            write_pair(idx);
        end
    endtask

    // Image stream runs a full FIFO ahead of the mask stream in every block
    task automatic send_frame_image_first();
        queue_expected_frame();
        for (int base = 0; base < PIXELS; base += `FIFO_DEPTH) begin
            while (recv_pixels < sent_pairs) @(negedge clock);
            for (int idx = base; idx < base + `FIFO_DEPTH; idx++) begin
                while (image_full) @(negedge clock);
                image_wr_en = 1'b1;
                image_din   = image_frame[idx];
                @(negedge clock);
                image_wr_en = 1'b0;
            end
            repeat (3) @(negedge clock);
            if (image_full != 1'b1) begin
                $display("ERR image_full got %h expected %h", image_full, 1'b1);
                drive_errors++;
            end
            if (recv_pixels != sent_pairs) begin
                $display("Pixels came out while the mask FIFO was empty");
                drive_errors++;
            end
            for (int idx = base; idx < base + `FIFO_DEPTH; idx++) begin
                while (mask_full) @(negedge clock);
                mask_wr_en = 1'b1;
                mask_din   = mask_frame[idx];
                @(negedge clock);
                mask_wr_en = 1'b0;
                sent_pairs++;
            end
        end
    endtask

    always @(negedge clock) begin : compare_outputs
        int  col;
        int  row;
        bit  exp_flag;
        bit  last;
        int  exp_count;
        col  = recv_pixels % `IMG_WIDTH;
        row  = (recv_pixels / `IMG_WIDTH) % `IMG_HEIGHT;
        last = ((recv_pixels % PIXELS) == PIXELS - 1);
        if (!reset && pixel_valid) begin
            if (exp_flags.size() == 0) begin
                $display("pixel_valid seen with no pixel outstanding at %0t", $time);
                compare_errors++;
            end else begin
                exp_flag = exp_flags.pop_front();
                if (int'(lane_pixel.pos.col) != col) begin
                    $display("ERR lane_pixel.pos.col got %h expected %h", lane_pixel.pos.col, col);
                    compare_errors++;
                end
                if (int'(lane_pixel.pos.row) != row) begin
                    $display("ERR lane_pixel.pos.row got %h expected %h", lane_pixel.pos.row, row);
                    compare_errors++;
                end
                if (lane_pixel.masked_edge != exp_flag) begin
                    $display("ERR lane_pixel.masked_edge got %h expected %h at pixel %0d",
                             lane_pixel.masked_edge, exp_flag, recv_pixels);
                    compare_errors++;
                end
            end
        end
        if (!reset && frame_done != (pixel_valid && last)) begin
            $display("ERR frame_done got %h expected %h", frame_done, pixel_valid && last);
            compare_errors++;
        end
        if (!reset && frame_done) begin
            if (exp_counts.size() == 0) begin
                $display("frame_done seen with no frame outstanding at %0t", $time);
                compare_errors++;
            end else begin
                exp_count = exp_counts.pop_front();
                if (int'(edge_count) != exp_count) begin
                    $display("ERR edge_count got %h expected %h", edge_count, exp_count);
                    compare_errors++;
                end
            end
            recv_frames++;
        end
        if (!reset && pixel_valid) begin
            recv_pixels++;
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Run timed out after %0d cycles with %0d of %0d pixels received",
                 WATCHDOG_CYCLES, recv_pixels, NUM_FRAMES * PIXELS);
        $display("Errors: %0d, pixels: %0d, frames: %0d",
                 drive_errors + compare_errors, recv_pixels, recv_frames);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        void'($urandom(32'h3f5a_bb25));
        clock       = 1'b0;
        reset       = 1'b1;
        image_wr_en = 1'b0;
        image_din   = DARK;
        mask_wr_en  = 1'b0;
        mask_din    = DARK;
        repeat (4) @(negedge clock);
        reset = 1'b0;

        // Idle outputs after reset, before any write
        repeat (8) begin
            @(negedge clock);
            if (pixel_valid || frame_done || image_full || mask_full || edge_count != '0) begin
                $display("ERR idle pixel_valid %h frame_done %h image_full %h",
                         pixel_valid, frame_done, image_full);
                $display("ERR idle mask_full %h edge_count %h", mask_full, edge_count);
                drive_errors++;
            end
        end

        fill_frame(0);
        send_frame(0);
        fill_frame(1);
        send_frame(0);
        fill_frame(2);
        send_frame(0);
        fill_frame(3);
        send_frame(0);
        fill_frame(0);
        send_frame_image_first();
        fill_frame(0);
        send_frame(3);
        fill_frame(0);
        send_frame(3);

        while (recv_pixels < NUM_FRAMES * PIXELS) @(negedge clock);
        repeat (6) @(negedge clock);
        if (recv_frames != NUM_FRAMES || exp_flags.size() != 0 || exp_counts.size() != 0) begin
            $display("Frame results missing: %0d of %0d frames seen",
                     recv_frames, NUM_FRAMES);
            drive_errors++;
        end
        $display("Errors: %0d, pixels: %0d, frames: %0d",
                 drive_errors + compare_errors, recv_pixels, recv_frames);
        if (drive_errors + compare_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+include
source/lane_pkg.sv
source/pixel_fifo.sv
source/edge_detector.sv
source/mask_region.sv
source/roi_combiner.sv
source/lane_edge_top.sv
dv/lane_edge_tb.sv

/* run.sh */
#!/bin/sh
# Builds the lane edge testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module lane_edge_tb -o lane_edge_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/lane_edge_sim)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "=== PASS ==="; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
